// File: source/hexdump_pkg.sv
package hexdump_pkg;

    localparam int BIT_ADDR_W  = 13;  // 8192 bits of page data
    localparam int BYTE_ADDR_W = 10;  // same page seen as 1024 bytes
    localparam int PAGE_W      = 12;  // page number printed as 3 hex digits

    typedef logic [7:0] char_t;  // one character on the FIFO bus

    localparam char_t ASCII_CR    = 8'h0D;
    localparam char_t ASCII_SPACE = 8'h20;

    typedef enum logic [1:0] {
        TOK_BYTE  = 2'd0,  // two hex chars with the high nibble first
        TOK_DIGIT = 2'd1,  // one hex char from the low nibble
        TOK_SPACE = 2'd2,
        TOK_CR    = 2'd3
    } tok_kind_e;

    typedef struct packed {
        tok_kind_e   kind;
        logic [7:0]  value;
    } token_t;

    // 0-9 map to '0'-'9' and 10-15 map to 'A'-'F'
    function automatic char_t nibble_ascii(input logic [3:0] nib);
        char_t c;
        if (nib < 4'd10) begin
            c = 8'h30 + {4'h0, nib};
        end else begin
            c = 8'h37 + {4'h0, nib};  // 'A' is 0x41 = 0x37 + 10
        end
        return c;
    endfunction

endpackage

// File: source/page_buffer.sv
`timescale 1ns/1ps

module page_buffer (
    input  logic                               MCLK,
    input  logic                               rst,
    input  logic                               wr_en,
    input  logic [hexdump_pkg::BIT_ADDR_W-1:0]  wr_addr,
    input  logic                               wr_data,
    input  logic                               rd_en,
    input  logic [hexdump_pkg::BYTE_ADDR_W-1:0] rd_addr,
    output logic [7:0]                         rd_data
);

    import hexdump_pkg::*;

    localparam int DEPTH = 1 << BYTE_ADDR_W;

    logic [7:0] mem [0:DEPTH-1];  // page contents

    // upper address bits pick the byte and the low three pick the bit
    always_ff @(posedge MCLK) begin
        if (wr_en) begin
            mem[wr_addr[BIT_ADDR_W-1:3]][wr_addr[2:0]] <= wr_data;
        end
    end

    // one cycle read latency and data held until the next read
    always_ff @(posedge MCLK) begin
        if (rst) begin
            rd_data <= 8'h00;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: source/dump_sequencer.sv
`timescale 1ns/1ps

module dump_sequencer #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16
) (
    input  logic                                MCLK,
    input  logic                                rst,
    input  logic                                send_boot,
    input  logic                                send_user,
    input  logic [hexdump_pkg::PAGE_W-1:0]      page,
    input  logic [7:0]                          rd_data,
    input  logic                                tok_ready,
    output logic                                rd_en,
    output logic [hexdump_pkg::BYTE_ADDR_W-1:0] rd_addr,
    output logic                                tok_valid,
    output hexdump_pkg::token_t                 tok
);

    import hexdump_pkg::*;

    localparam int MAX_LINES = (BOOT_LINES > USER_LINES) ? BOOT_LINES : USER_LINES;
    localparam int LINE_W    = $clog2(MAX_LINES + 1);
    localparam int BYTE_W    = $clog2(BYTES_PER_LINE + 1);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_DIGIT,    // page number digits of a user dump
        ST_PAGE_CR,
        ST_READ,     // one cycle buffer read
        ST_BYTE,
        ST_SPACE,
        ST_LINE_CR,
        ST_END_CR,   // closing CR after the last line
        ST_REARM     // wait for both requests to drop
    } state_e;

    state_e              state;
    logic                is_user;
    logic [PAGE_W-1:0]   page_q;
    logic [1:0]          dig_cnt;
    logic [LINE_W-1:0]   line_cnt;
    logic [BYTE_W-1:0]   byte_cnt;
    logic [LINE_W-1:0]   last_line;
    logic                xfer;

    assign last_line = is_user ? LINE_W'(USER_LINES - 1) : LINE_W'(BOOT_LINES - 1);
    assign xfer      = tok_valid & tok_ready;
    assign rd_en     = (state == ST_READ);

    // token presented by the current state and held until taken
    always_comb begin
        tok_valid  = 1'b1;
        tok.kind   = TOK_CR;
        tok.value  = 8'h00;
        case (state)
            ST_DIGIT: begin
                tok.kind  = TOK_DIGIT;
                tok.value = {4'h0, page_q[PAGE_W-1 -: 4]};  // top digit first
            end
            ST_BYTE: begin
                tok.kind  = TOK_BYTE;
                tok.value = rd_data;
            end
            ST_SPACE:   tok.kind = TOK_SPACE;
            ST_PAGE_CR,
            ST_LINE_CR,
            ST_END_CR:  tok.kind = TOK_CR;
            default:    tok_valid = 1'b0;
        endcase
    end

    always_ff @(posedge MCLK) begin
        if (rst) begin
            state    <= ST_IDLE;
            is_user  <= 1'b0;
            page_q   <= '0;
            dig_cnt  <= '0;
            line_cnt <= '0;
            byte_cnt <= '0;
            rd_addr  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    rd_addr  <= '0;
                    line_cnt <= '0;
                    byte_cnt <= '0;
                    dig_cnt  <= '0;
                    page_q   <= page;
                    if (send_boot) begin  // boot has priority
                        is_user <= 1'b0;
                        state   <= ST_READ;
                    end else if (send_user) begin
                        is_user <= 1'b1;
                        state   <= ST_DIGIT;
                    end
                end
                ST_DIGIT: if (xfer) begin
                    page_q  <= page_q << 4;
                    dig_cnt <= dig_cnt + 2'd1;
                    if (dig_cnt == 2'd2) begin
                        state <= ST_PAGE_CR;
                    end
                end
                ST_PAGE_CR: if (xfer) state <= ST_READ;
                ST_READ:    state <= ST_BYTE;  // rd_data valid next cycle
                ST_BYTE: if (xfer) begin
                    rd_addr <= rd_addr + 1'b1;
                    state   <= ST_SPACE;
                end
                ST_SPACE: if (xfer) begin
                    if (byte_cnt == BYTE_W'(BYTES_PER_LINE - 1)) begin
                        byte_cnt <= '0;
                        state    <= ST_LINE_CR;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                        state    <= ST_READ;
                    end
                end
                ST_LINE_CR: if (xfer) begin
                    if (line_cnt == last_line) begin
                        state <= ST_END_CR;
                    end else begin
                        line_cnt <= line_cnt + 1'b1;
                        state    <= ST_READ;
                    end
                end
                ST_END_CR: if (xfer) state <= ST_REARM;
                ST_REARM: begin
                    if (!send_boot && !send_user) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     MCLK,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     out_ready,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data
);

    payload_t skid_data;
    logic     skid_valid;
    logic     in_xfer;

    assign in_ready = ~skid_valid;  // comes straight from a flop
    assign in_xfer  = in_valid & in_ready;

    always_ff @(posedge MCLK) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_valid || out_ready) begin
            // output slot free or draining this cycle
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_xfer;
            end
        end else if (in_xfer) begin
            skid_valid <= 1'b1;  // park the new word while the output stalls
        end
    end

    always_ff @(posedge MCLK) begin
        if (!out_valid || out_ready) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_xfer) begin
                out_data <= in_data;
            end
        end else if (in_xfer) begin
            skid_data <= in_data;
        end
    end

endmodule

// File: source/ascii_encoder.sv
`timescale 1ns/1ps

module ascii_encoder (
    input  logic                MCLK,
    input  logic                rst,
    input  logic                tok_valid,
    input  hexdump_pkg::token_t tok,
    input  logic                chr_ready,
    output logic                tok_ready,
    output logic                chr_valid,
    output hexdump_pkg::char_t  chr
);

    import hexdump_pkg::*;

    logic  phase;     // set while the low nibble of a byte is pending
    logic  can_emit;
    logic  emit;
    logic  is_byte;
    char_t next_chr;

    assign can_emit  = ~chr_valid | chr_ready;
    assign emit      = tok_valid & can_emit;
    assign is_byte   = (tok.kind == TOK_BYTE);
    assign tok_ready = can_emit & (~is_byte | phase);  // byte token leaves on 2nd char

    always_comb begin
        case (tok.kind)
            TOK_BYTE:  next_chr = nibble_ascii(phase ? tok.value[3:0] : tok.value[7:4]);
            TOK_DIGIT: next_chr = nibble_ascii(tok.value[3:0]);
            TOK_SPACE: next_chr = ASCII_SPACE;
            default:   next_chr = ASCII_CR;
        endcase
    end

    always_ff @(posedge MCLK) begin
        if (rst) begin
            chr_valid <= 1'b0;
            phase     <= 1'b0;
        end else begin
            if (can_emit) begin
                chr_valid <= tok_valid;
            end
            if (emit) begin
                phase <= is_byte & ~phase;
            end
        end
    end

    always_ff @(posedge MCLK) begin
        if (emit) begin
            chr <= next_chr;
        end
    end

endmodule

// File: source/fifo_writer.sv
`timescale 1ns/1ps

module fifo_writer #(
    parameter int WR_LOW_CYCLES = 2
) (
    input  logic               MCLK,
    input  logic               rst,
    input  logic               chr_valid,
    input  hexdump_pkg::char_t chr,
    input  logic               txe_n,
    output logic               chr_ready,
    output hexdump_pkg::char_t fifo_data,
    output logic               wr_n
);

    localparam int CNT_W = $clog2(WR_LOW_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,   // wr_n held low
        ST_RECOVER   // wr_n high before the next write
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] low_cnt;

    // only take a character while the FT245 has room
    assign chr_ready = (state == ST_IDLE) & ~txe_n;

    always_ff @(posedge MCLK) begin
        if (rst) begin
            state     <= ST_IDLE;
            low_cnt   <= '0;
            wr_n      <= 1'b1;
            fifo_data <= 8'h00;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (chr_valid && chr_ready) begin
                        fifo_data <= chr;  // stays put until wr_n rises
                        wr_n      <= 1'b0;
                        low_cnt   <= CNT_W'(WR_LOW_CYCLES - 1);
                        state     <= ST_STROBE;
                    end
                end
                ST_STROBE: begin
                    if (low_cnt == '0) begin
                        wr_n  <= 1'b1;  // FT245 latches data on this edge
                        state <= ST_RECOVER;
                    end else begin
                        low_cnt <= low_cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: source/bubble_dump_top.sv
`timescale 1ns/1ps

module bubble_dump_top #(
    parameter int BOOT_LINES     = 30,
    parameter int USER_LINES     = 8,
    parameter int BYTES_PER_LINE = 16,
    parameter int WR_LOW_CYCLES  = 2
) (
    input  logic                               MCLK,
    input  logic                               rst,
    input  logic                               buf_wr_en,
    input  logic [hexdump_pkg::BIT_ADDR_W-1:0] buf_wr_addr,
    input  logic                               buf_wr_data,
    input  logic                               send_boot,
    input  logic                               send_user,
    input  logic [hexdump_pkg::PAGE_W-1:0]     page,
    input  logic                               txe_n,
    output logic                               wr_n,
    output logic [7:0]                         fifo_data
);

    import hexdump_pkg::*;

    logic                   rd_en;
    logic [BYTE_ADDR_W-1:0] rd_addr;
    logic [7:0]             rd_data;

    logic   seq_valid, seq_ready;    // sequencer to skid A
    token_t seq_tok;
    logic   enc_tok_valid, enc_tok_ready;
    token_t enc_tok;
    logic   enc_valid, enc_ready;    // encoder to skid B
    char_t  enc_chr;
    logic   wr_chr_valid, wr_chr_ready;
    char_t  wr_chr;

    page_buffer i_page_buffer (
        .MCLK    (MCLK),
        .rst     (rst),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dump_sequencer #(
        .BOOT_LINES     (BOOT_LINES),
        .USER_LINES     (USER_LINES),
        .BYTES_PER_LINE (BYTES_PER_LINE)
    ) i_dump_sequencer (
        .MCLK      (MCLK),
        .rst       (rst),
        .send_boot (send_boot),
        .send_user (send_user),
        .page      (page),
        .rd_data   (rd_data),
        .tok_ready (seq_ready),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .tok_valid (seq_valid),
        .tok       (seq_tok)
    );

    skid_buffer #(.payload_t(token_t)) i_skid_tok (
        .MCLK      (MCLK),
        .rst       (rst),
        .in_valid  (seq_valid),
        .in_data   (seq_tok),
        .out_ready (enc_tok_ready),
        .in_ready  (seq_ready),
        .out_valid (enc_tok_valid),
        .out_data  (enc_tok)
    );

    ascii_encoder i_ascii_encoder (
        .MCLK      (MCLK),
        .rst       (rst),
        .tok_valid (enc_tok_valid),
        .tok       (enc_tok),
        .chr_ready (enc_ready),
        .tok_ready (enc_tok_ready),
        .chr_valid (enc_valid),
        .chr       (enc_chr)
    );

    skid_buffer #(.payload_t(char_t)) i_skid_chr (
        .MCLK      (MCLK),
        .rst       (rst),
        .in_valid  (enc_valid),
        .in_data   (enc_chr),
        .out_ready (wr_chr_ready),
        .in_ready  (enc_ready),
        .out_valid (wr_chr_valid),
        .out_data  (wr_chr)
    );

    fifo_writer #(.WR_LOW_CYCLES(WR_LOW_CYCLES)) i_fifo_writer (
        .MCLK      (MCLK),
        .rst       (rst),
        .chr_valid (wr_chr_valid),
        .chr       (wr_chr),
        .txe_n     (txe_n),
        .chr_ready (wr_chr_ready),
        .fifo_data (fifo_data),
        .wr_n      (wr_n)
    );

endmodule

// File: test/tb_bubble_dump.sv
`timescale 1ns/1ps

module tb_bubble_dump;

    import hexdump_pkg::*;

    localparam int BOOT_LINES     = 30;
    localparam int USER_LINES     = 8;
    localparam int BYTES_PER_LINE = 16;
    localparam int WR_LOW_CYCLES  = 2;
    localparam int LINE_CHARS     = BYTES_PER_LINE * 3 + 1;  // "HH " groups plus CR
    localparam int BOOT_CHARS     = BOOT_LINES * LINE_CHARS + 1;
    localparam int USER_CHARS     = 4 + USER_LINES * LINE_CHARS + 1;
    localparam int BP_WINDOWS     = 40;
    localparam int BP_MAX_HIGH    = 30;
    localparam int SETTLE_CYCLES  = 40;
    localparam int REARM_WINDOW   = 300;
    localparam int FILL_CYCLES    = 1 << BIT_ADDR_W;
    localparam longint TOTAL_CHARS = 3 * BOOT_CHARS + 2 * USER_CHARS;
    localparam longint WATCHDOG_NS = (TOTAL_CHARS * 12 + BP_WINDOWS * BP_MAX_HIGH
                                     + FILL_CYCLES + REARM_WINDOW + 1000) * 40;

    logic                  MCLK;
    logic                  rst;
    logic                  buf_wr_en;
    logic [BIT_ADDR_W-1:0] buf_wr_addr;
    logic                  buf_wr_data;
    logic                  send_boot;
    logic                  send_user;
    logic [PAGE_W-1:0]     page;
    logic                  txe_n;
    logic                  wr_n;
    char_t                 fifo_data;

    logic [7:0] mem_model [0:(1<<BYTE_ADDR_W)-1];  // bytes written to the page
    char_t      exp_q[$];
    char_t      cap_q[$];
    int         err_cnt    = 0;
    int         pass_cnt   = 0;
    int         fail_cnt   = 0;
    int         strobe_cnt = 0;
    int         strobe_err = 0;
    int         low_width  = 0;
    bit         prev_wr_n  = 1'b1;
    bit         prev_txe_n = 1'b0;
    char_t      held_data;

    bubble_dump_top #(
        .BOOT_LINES     (BOOT_LINES),
        .USER_LINES     (USER_LINES),
        .BYTES_PER_LINE (BYTES_PER_LINE),
        .WR_LOW_CYCLES  (WR_LOW_CYCLES)
    ) i_bubble_dump_top (
        .MCLK        (MCLK),
        .rst         (rst),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .send_boot   (send_boot),
        .send_user   (send_user),
        .page        (page),
        .txe_n       (txe_n),
        .wr_n        (wr_n),
        .fifo_data   (fifo_data)
    );

    initial MCLK = 1'b0;
    always #20 MCLK = ~MCLK;

    task automatic compare_char(input char_t got, input char_t exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_strobe(input int width);
        strobe_cnt++;
        if (width != WR_LOW_CYCLES) begin
            $display("ERR %0t: wr_n low for %0d cycles, expected %0d",
                     $time, width, WR_LOW_CYCLES);
            strobe_err++;
            err_cnt++;
        end
    endtask

    // outputs are sampled mid-cycle away from the rising edge
    always @(negedge MCLK) begin
        if (!rst) begin
            if (prev_wr_n && !wr_n) begin  // strobe fell at the last rising edge
                cap_q.push_back(fifo_data);
                held_data = fifo_data;
                low_width = 1;
                if (prev_txe_n) begin  // txe_n as seen at the accepting edge
                    $display("ERR %0t: wr_n fell while txe_n was high", $time);
                    err_cnt++;
                end
            end else if (!prev_wr_n && !wr_n) begin
                low_width++;
                compare_char(fifo_data, held_data, "fifo_data during strobe");
            end else if (!prev_wr_n && wr_n) begin
                compare_strobe(low_width);
                compare_char(fifo_data, held_data, "fifo_data at wr_n rise");
            end
            prev_wr_n = wr_n;
        end
        prev_txe_n = txe_n;
    end

    // expected text of one dump from the page contents
    task automatic build_model(input bit user_dump, input logic [PAGE_W-1:0] pg);
        int addr;
        int lines;
        int l;
        int b;
        exp_q.delete();
        addr  = 0;
        lines = user_dump ? USER_LINES : BOOT_LINES;
        if (user_dump) begin
            exp_q.push_back(nibble_ascii(pg[11:8]));
            exp_q.push_back(nibble_ascii(pg[7:4]));
            exp_q.push_back(nibble_ascii(pg[3:0]));
            exp_q.push_back(ASCII_CR);
        end
        for (l = 0; l < lines; l++) begin
            for (b = 0; b < BYTES_PER_LINE; b++) begin
                exp_q.push_back(nibble_ascii(mem_model[addr][7:4]));
                exp_q.push_back(nibble_ascii(mem_model[addr][3:0]));
                exp_q.push_back(ASCII_SPACE);
                addr++;
            end
            exp_q.push_back(ASCII_CR);
        end
        exp_q.push_back(ASCII_CR);  // closing CR
    endtask

    task automatic fill_buffer();
        logic [7:0] b;
        int         a;
        int         k;
        for (a = 0; a < (1 << BYTE_ADDR_W); a++) begin
            b = 8'($urandom_range(0, 255));
            mem_model[a] = b;
            for (k = 0; k < 8; k++) begin  // bit 0 first
                @(posedge MCLK);
                buf_wr_en   <= 1'b1;
                buf_wr_addr <= BIT_ADDR_W'(a * 8 + k);
                buf_wr_data <= b[k];
            end
        end
        @(posedge MCLK);
        buf_wr_en <= 1'b0;
    endtask

    task automatic pulse_request(input bit boot, input bit user, input logic [PAGE_W-1:0] pg);
        @(posedge MCLK);
        send_boot <= boot;
        send_user <= user;
        page      <= pg;
        @(posedge MCLK);
        send_boot <= 1'b0;
        send_user <= 1'b0;
    endtask

    task automatic wait_for_dump(input int limit);
        int cycles;
        cycles = 0;
        while (cap_q.size() < exp_q.size() && cycles < limit) begin
            @(posedge MCLK);
            cycles++;
        end
        repeat (SETTLE_CYCLES) @(posedge MCLK);  // catches extra writes
    endtask

    task automatic check_dump();
        int n;
        int i;
        if (cap_q.size() != exp_q.size()) begin
            $display("character count wrong at %0t: expected %0d characters, captured %0d",
                     $time, exp_q.size(), cap_q.size());
            err_cnt++;
        end
        n = (cap_q.size() < exp_q.size()) ? cap_q.size() : exp_q.size();
        for (i = 0; i < n; i++) begin
            compare_char(cap_q[i], exp_q[i], $sformatf("character %0d", i));
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_boot_dump();
        int e0;
        e0 = err_cnt;
        fill_buffer();
        build_model(1'b0, '0);
        cap_q.delete();
        pulse_request(1'b1, 1'b0, '0);
        wait_for_dump(BOOT_CHARS * 12);
        check_dump();
        report_test("boot_dump", e0);
    endtask

    task automatic test_user_dump();
        int                e0;
        logic [PAGE_W-1:0] pg;
        e0 = err_cnt;
        pg = PAGE_W'($urandom());
        build_model(1'b1, pg);
        cap_q.delete();
        pulse_request(1'b0, 1'b1, pg);
        wait_for_dump(USER_CHARS * 12);
        check_dump();
        report_test("user_dump", e0);
    endtask

    task automatic test_back_pressure();
        int                e0;
        int                w;
        bit                stop;
        logic [PAGE_W-1:0] pg;
        e0   = err_cnt;
        stop = 1'b0;
        pg   = PAGE_W'($urandom());
        build_model(1'b1, pg);
        cap_q.delete();
        pulse_request(1'b0, 1'b1, pg);
        fork
            begin
                wait_for_dump(USER_CHARS * 12 + BP_WINDOWS * BP_MAX_HIGH);
                stop = 1'b1;
            end
            begin
                for (w = 0; w < BP_WINDOWS && !stop; w++) begin
                    repeat ($urandom_range(5, 40)) @(posedge MCLK);
                    txe_n <= 1'b1;  // FT245 full
                    repeat ($urandom_range(1, BP_MAX_HIGH)) @(posedge MCLK);
                    txe_n <= 1'b0;
                end
            end
        join
        check_dump();
        report_test("back_pressure", e0);
    endtask

    task automatic test_strobe_width();
        int e0;
        e0 = err_cnt;
        if (strobe_err != 0) begin
            $display("%0d write strobes had the wrong width", strobe_err);
            err_cnt++;
        end
        if (strobe_cnt != BOOT_CHARS + 2 * USER_CHARS) begin
            $display("measured %0d strobe widths, but %0d characters were sent",
                     strobe_cnt, BOOT_CHARS + 2 * USER_CHARS);
            err_cnt++;
        end
        report_test("strobe_width", e0);
    endtask

    task automatic test_rearm_priority();
        int e0;
        int n;
        e0 = err_cnt;
        build_model(1'b0, '0);
        cap_q.delete();
        @(posedge MCLK);
        send_boot <= 1'b1;  // held past the end of the dump
        wait_for_dump(BOOT_CHARS * 12);
        check_dump();
        n = cap_q.size();
        repeat (REARM_WINDOW) @(posedge MCLK);
        if (cap_q.size() != n) begin
            $display("dump restarted while send_boot stayed high: %0d extra characters",
                     cap_q.size() - n);
            err_cnt++;
        end
        @(posedge MCLK);
        send_boot <= 1'b0;
        repeat (2) @(posedge MCLK);
        cap_q.delete();
        pulse_request(1'b1, 1'b1, PAGE_W'($urandom()));  // boot must win
        wait_for_dump(BOOT_CHARS * 12);
        check_dump();
        report_test("rearm_priority", e0);
    endtask

    initial begin
        void'($urandom(18199));
        rst         <= 1'b1;
        buf_wr_en   <= 1'b0;
        buf_wr_addr <= '0;
        buf_wr_data <= 1'b0;
        send_boot   <= 1'b0;
        send_user   <= 1'b0;
        page        <= '0;
        txe_n       <= 1'b0;
        repeat (3) @(posedge MCLK);
        rst <= 1'b0;
        test_boot_dump();
        test_user_dump();
        test_back_pressure();
        test_strobe_width();
        test_rearm_priority();
        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the dumps did not complete", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: bubble_dump_top.f
source/hexdump_pkg.sv
source/page_buffer.sv
source/dump_sequencer.sv
source/skid_buffer.sv
source/ascii_encoder.sv
source/fifo_writer.sv
source/bubble_dump_top.sv
test/tb_bubble_dump.sv

// File: Bender.yml
package:
  name: bubble_dump

sources:
  - source/hexdump_pkg.sv
  - source/page_buffer.sv
  - source/dump_sequencer.sv
  - source/skid_buffer.sv
  - source/ascii_encoder.sv
  - source/fifo_writer.sv
  - source/bubble_dump_top.sv
  - target: test
    files:
      - test/tb_bubble_dump.sv
